// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := csr_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
PASS_MSG  := Testbench passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
hw/csr_num_pkg.sv
hw/csr_exc_pkg.sv
hw/csr_wr_if.sv
hw/csr_write_decode.sv
hw/csr_exc_regs.sv
hw/csr_timer.sv
hw/csr_read_mux.sv
hw/csr_top.sv
verif/csr_assertions.sv
verif/csr_tb.sv

// ==== hw/csr_exc_pkg.sv ====
package csr_exc_pkg;

    typedef logic [31:0] csr_word_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;
    typedef logic [1:0]  plv_t;
    typedef logic [12:0] int_vec_t;

    localparam int TIMER_IRQ_BIT = 11;

    localparam ecode_t ECODE_INT  = 6'h00;
    localparam ecode_t ECODE_ADEF = 6'h08;
    localparam ecode_t ECODE_ALE  = 6'h09;
    localparam ecode_t ECODE_SYS  = 6'h0b;
    localparam ecode_t ECODE_BRK  = 6'h0c;
    localparam ecode_t ECODE_INE  = 6'h0d;

    // masked bits take the new value, the rest keep the old one
    function automatic csr_word_t mask_merge(
        input csr_word_t old_val,
        input csr_word_t mask,
        input csr_word_t val
    );
        return (mask & val) | (~mask & old_val);
    endfunction

endpackage

// ==== hw/csr_exc_regs.sv ====
module csr_exc_regs #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    csr_wr_if.dst                     wr,
    input  logic                      exc,
    input  csr_exc_pkg::ecode_t       ecode,
    input  csr_exc_pkg::esubcode_t    esubcode,
    input  csr_exc_pkg::csr_word_t    pc,
    input  csr_exc_pkg::csr_word_t    badvaddr,
    input  logic                      badv_is_pc,
    input  logic                      badv_is_mem,
    input  logic                      ertn,
    input  logic                      timer_zero,
    output csr_exc_pkg::plv_t         crmd_plv,
    output logic                      has_int,
    output csr_exc_pkg::csr_word_t    exc_entry,
    output csr_exc_pkg::csr_word_t    exc_retaddr,
    output csr_exc_pkg::csr_word_t    crmd_word,
    output csr_exc_pkg::csr_word_t    prmd_word,
    output csr_exc_pkg::csr_word_t    ecfg_word,
    output csr_exc_pkg::csr_word_t    estat_word,
    output csr_exc_pkg::csr_word_t    era_word,
    output csr_exc_pkg::csr_word_t    badv_word,
    output csr_exc_pkg::csr_word_t    eentry_word,
    output csr_exc_pkg::csr_word_t    tid_word,
    output csr_exc_pkg::csr_word_t    save_word [SAVE_COUNT]
);
    import csr_num_pkg::*;
    import csr_exc_pkg::*;

    logic                     crmd_ie;
    plv_t                     prmd_pplv;
    logic                     prmd_pie;
    int_vec_t                 ecfg_lie;
    logic [ESTAT_SWI_MSB:0]   estat_swi;
    logic                     timer_irq;
    int_vec_t                 estat_is;
    ecode_t                   estat_ecode;
    esubcode_t                estat_esubcode;
    csr_word_t                era;
    csr_word_t                badv;
    logic [31:EENTRY_VA_LSB]  eentry_va;
    csr_word_t                tid;

    logic wr_crmd, wr_prmd, wr_ecfg, wr_estat, wr_era, wr_badv, wr_eentry, wr_tid;
    logic ticlr_clr;

    assign wr_crmd   = wr.we && (wr.sel == SEL_CRMD);
    assign wr_prmd   = wr.we && (wr.sel == SEL_PRMD);
    assign wr_ecfg   = wr.we && (wr.sel == SEL_ECFG);
    assign wr_estat  = wr.we && (wr.sel == SEL_ESTAT);
    assign wr_era    = wr.we && (wr.sel == SEL_ERA);
    assign wr_badv   = wr.we && (wr.sel == SEL_BADV);
    assign wr_eentry = wr.we && (wr.sel == SEL_EENTRY);
    assign wr_tid    = wr.we && (wr.sel == SEL_TID);
    // TICLR reads zero, so CLR must be both masked and set
    assign ticlr_clr = wr.we && (wr.sel == SEL_TICLR) &&
                       wr.wmask[TICLR_CLR] && wr.wval[TICLR_CLR];

    csr_word_t crmd_next, prmd_next, ecfg_next, estat_next;
    csr_word_t era_next, badv_next, eentry_next, tid_next;

    assign crmd_next   = mask_merge(crmd_word, wr.wmask, wr.wval);
    assign prmd_next   = mask_merge(prmd_word, wr.wmask, wr.wval);
    assign ecfg_next   = mask_merge(ecfg_word, wr.wmask, wr.wval);
    assign estat_next  = mask_merge(estat_word, wr.wmask, wr.wval);
    assign era_next    = mask_merge(era_word, wr.wmask, wr.wval);
    assign badv_next   = mask_merge(badv_word, wr.wmask, wr.wval);
    assign eentry_next = mask_merge(eentry_word, wr.wmask, wr.wval);
    assign tid_next    = mask_merge(tid_word, wr.wmask, wr.wval);

    // exception entry wins over ertn, ertn over software writes
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (exc) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_crmd) begin
            crmd_plv <= crmd_next[CRMD_PLV_MSB:CRMD_PLV_LSB];
            crmd_ie  <= crmd_next[CRMD_IE];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (exc) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wr_prmd) begin
            prmd_pplv <= prmd_next[PRMD_PPLV_MSB:PRMD_PPLV_LSB];
            prmd_pie  <= prmd_next[PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg_lie  <= '0;
            estat_swi <= '0;
            eentry_va <= '0;
            tid       <= '0;
        end else begin
            if (wr_ecfg) ecfg_lie <= ecfg_next[ECFG_LIE_MSB:0];
            if (wr_estat) estat_swi <= estat_next[ESTAT_SWI_MSB:0];
            if (wr_eentry) eentry_va <= eentry_next[31:EENTRY_VA_LSB];
            if (wr_tid) tid <= tid_next;
        end
    end

    // timer interrupt pending bit
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_irq <= 1'b0;
        end else if (timer_zero) begin
            timer_irq <= 1'b1;
        end else if (ticlr_clr) begin
            timer_irq <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era            <= '0;
            badv           <= '0;
        end else if (exc) begin
            estat_ecode    <= ecode;
            estat_esubcode <= esubcode;
            era            <= pc;
            if (badv_is_pc) begin
                badv <= pc;
            end else if (badv_is_mem) begin
                badv <= badvaddr;
            end
        end else begin
            if (wr_era) era <= era_next;
            if (wr_badv) badv <= badv_next;
        end
    end

    for (genvar i = 0; i < SAVE_COUNT; i++) begin : g_save
        csr_word_t save_q;

        always_ff @(posedge clk) begin
            if (rst) begin
                save_q <= '0;
            end else if (wr.we && (wr.sel == csr_sel_t'(int'(SEL_SAVE0) + i))) begin
                save_q <= mask_merge(save_q, wr.wmask, wr.wval);
            end
        end

        assign save_word[i] = save_q;
    end

    // hardware lines 9:2, bit 10 and IPI are not implemented
    always_comb begin
        estat_is                   = '0;
        estat_is[ESTAT_SWI_MSB:0]  = estat_swi;
        estat_is[TIMER_IRQ_BIT]    = timer_irq;
    end

    always_comb begin
        crmd_word                             = '0;
        crmd_word[CRMD_PLV_MSB:CRMD_PLV_LSB]  = crmd_plv;
        crmd_word[CRMD_IE]                    = crmd_ie;
        prmd_word                             = '0;
        prmd_word[PRMD_PPLV_MSB:PRMD_PPLV_LSB] = prmd_pplv;
        prmd_word[PRMD_PIE]                   = prmd_pie;
        estat_word                            = '0;
        estat_word[ESTAT_IS_MSB:0]            = estat_is;
        estat_word[ESTAT_ECODE_MSB:ESTAT_ECODE_LSB] = estat_ecode;
        estat_word[ESTAT_ESUB_MSB:ESTAT_ESUB_LSB]   = estat_esubcode;
    end

    assign ecfg_word   = csr_word_t'(ecfg_lie);
    assign era_word    = era;
    assign badv_word   = badv;
    assign eentry_word = {eentry_va, {EENTRY_VA_LSB{1'b0}}};
    assign tid_word    = tid;

    assign exc_entry   = eentry_word;
    assign exc_retaddr = era;
    assign has_int     = (|(estat_is & ecfg_lie)) & crmd_ie;

endmodule

// ==== hw/csr_num_pkg.sv ====
package csr_num_pkg;

    typedef logic [13:0] csr_num_t;

    localparam csr_num_t CSR_CRMD   = 14'h000;
    localparam csr_num_t CSR_PRMD   = 14'h001;
    localparam csr_num_t CSR_ECFG   = 14'h004;
    localparam csr_num_t CSR_ESTAT  = 14'h005;
    localparam csr_num_t CSR_ERA    = 14'h006;
    localparam csr_num_t CSR_BADV   = 14'h007;
    localparam csr_num_t CSR_EENTRY = 14'h00c;
    localparam csr_num_t CSR_SAVE0  = 14'h030;
    localparam csr_num_t CSR_SAVE1  = 14'h031;
    localparam csr_num_t CSR_SAVE2  = 14'h032;
    localparam csr_num_t CSR_SAVE3  = 14'h033;
    localparam csr_num_t CSR_TID    = 14'h040;
    localparam csr_num_t CSR_TCFG   = 14'h041;
    localparam csr_num_t CSR_TVAL   = 14'h042;
    localparam csr_num_t CSR_TICLR  = 14'h044;

    // field positions
    localparam int CRMD_PLV_LSB     = 0;
    localparam int CRMD_PLV_MSB     = 1;
    localparam int CRMD_IE          = 2;
    localparam int PRMD_PPLV_LSB    = 0;
    localparam int PRMD_PPLV_MSB    = 1;
    localparam int PRMD_PIE         = 2;
    localparam int ECFG_LIE_MSB     = 12;
    localparam int ESTAT_IS_MSB     = 12;
    localparam int ESTAT_SWI_MSB    = 1;
    localparam int ESTAT_ECODE_LSB  = 16;
    localparam int ESTAT_ECODE_MSB  = 21;
    localparam int ESTAT_ESUB_LSB   = 22;
    localparam int ESTAT_ESUB_MSB   = 30;
    localparam int EENTRY_VA_LSB    = 6;
    localparam int TCFG_EN          = 0;
    localparam int TCFG_PERIODIC    = 1;
    localparam int TCFG_INITVAL_LSB = 2;
    localparam int TICLR_CLR        = 0;

    // save entries must stay consecutive
    typedef enum logic [4:0] {
        SEL_NONE,
        SEL_CRMD,
        SEL_PRMD,
        SEL_ECFG,
        SEL_ESTAT,
        SEL_ERA,
        SEL_BADV,
        SEL_EENTRY,
        SEL_SAVE0,
        SEL_SAVE1,
        SEL_SAVE2,
        SEL_SAVE3,
        SEL_TID,
        SEL_TCFG,
        SEL_TVAL,
        SEL_TICLR
    } csr_sel_t;

endpackage

// ==== hw/csr_read_mux.sv ====
module csr_read_mux #(
    parameter int SAVE_COUNT = 4
) (
    input  csr_num_pkg::csr_num_t  rnum,
    input  csr_exc_pkg::csr_word_t crmd_word,
    input  csr_exc_pkg::csr_word_t prmd_word,
    input  csr_exc_pkg::csr_word_t ecfg_word,
    input  csr_exc_pkg::csr_word_t estat_word,
    input  csr_exc_pkg::csr_word_t era_word,
    input  csr_exc_pkg::csr_word_t badv_word,
    input  csr_exc_pkg::csr_word_t eentry_word,
    input  csr_exc_pkg::csr_word_t tid_word,
    input  csr_exc_pkg::csr_word_t save_word [SAVE_COUNT],
    input  csr_exc_pkg::csr_word_t tcfg_word,
    input  csr_exc_pkg::csr_word_t tval_word,
    output csr_exc_pkg::csr_word_t rval
);
    import csr_num_pkg::*;

    always_comb begin
        case (rnum)
            CSR_CRMD:   rval = crmd_word;
            CSR_PRMD:   rval = prmd_word;
            CSR_ECFG:   rval = ecfg_word;
            CSR_ESTAT:  rval = estat_word;
            CSR_ERA:    rval = era_word;
            CSR_BADV:   rval = badv_word;
            CSR_EENTRY: rval = eentry_word;
            CSR_TID:    rval = tid_word;
            CSR_TCFG:   rval = tcfg_word;
            CSR_TVAL:   rval = tval_word;
            // TICLR is write-only
            default:    rval = '0;
        endcase
        for (int i = 0; i < SAVE_COUNT; i++) begin
            if (rnum == CSR_SAVE0 + csr_num_t'(i)) begin
                rval = save_word[i];
            end
        end
    end

endmodule

// ==== hw/csr_timer.sv ====
module csr_timer (
    input  logic                   clk,
    input  logic                   rst,
    csr_wr_if.dst                  wr,
    output logic                   timer_zero,
    output csr_exc_pkg::csr_word_t tcfg_word,
    output csr_exc_pkg::csr_word_t tval_word
);
    import csr_num_pkg::*;
    import csr_exc_pkg::*;

    logic                       tcfg_en;
    logic                       tcfg_periodic;
    logic [31:TCFG_INITVAL_LSB] tcfg_initval;
    csr_word_t                  tcfg_next;
    logic                       wr_tcfg;
    csr_word_t                  count;

    assign wr_tcfg   = wr.we && (wr.sel == SEL_TCFG);
    assign tcfg_next = mask_merge(tcfg_word, wr.wmask, wr.wval);

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (wr_tcfg) begin
            tcfg_en       <= tcfg_next[TCFG_EN];
            tcfg_periodic <= tcfg_next[TCFG_PERIODIC];
            tcfg_initval  <= tcfg_next[31:TCFG_INITVAL_LSB];
        end
    end

    // load uses the merged value so the new INITVAL counts right away
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '1;
        end else if (wr_tcfg && tcfg_next[TCFG_EN]) begin
            count <= {tcfg_next[31:TCFG_INITVAL_LSB], {TCFG_INITVAL_LSB{1'b0}}};
        end else if (tcfg_en && count != '1) begin
            if (count == '0 && tcfg_periodic) begin
                count <= {tcfg_initval, {TCFG_INITVAL_LSB{1'b0}}};
            end else begin
                // one-shot wraps to all ones and parks there
                count <= count - 1'b1;
            end
        end
    end

    assign tcfg_word  = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tval_word  = count;
    assign timer_zero = tcfg_en && (count == '0);

endmodule

// ==== hw/csr_top.sv ====
module csr_top #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   we,
    input  csr_num_pkg::csr_num_t  wnum,
    input  csr_exc_pkg::csr_word_t wmask,
    input  csr_exc_pkg::csr_word_t wval,
    input  csr_num_pkg::csr_num_t  rnum,
    output csr_exc_pkg::csr_word_t rval,
    input  logic                   exc,
    input  csr_exc_pkg::ecode_t    ecode,
    input  csr_exc_pkg::esubcode_t esubcode,
    input  csr_exc_pkg::csr_word_t pc,
    input  csr_exc_pkg::csr_word_t badvaddr,
    input  logic                   badv_is_pc,
    input  logic                   badv_is_mem,
    input  logic                   ertn,
    output logic                   has_int,
    output csr_exc_pkg::csr_word_t exc_entry,
    output csr_exc_pkg::csr_word_t exc_retaddr,
    output csr_exc_pkg::plv_t      crmd_plv
);
    import csr_exc_pkg::*;

    csr_wr_if wr ();

    logic      timer_zero;
    csr_word_t crmd_word, prmd_word, ecfg_word, estat_word;
    csr_word_t era_word, badv_word, eentry_word, tid_word;
    csr_word_t tcfg_word, tval_word;
    csr_word_t save_word [SAVE_COUNT];

    csr_write_decode #(.SAVE_COUNT(SAVE_COUNT)) u_write_decode (
        .we(we), .wnum(wnum), .wmask(wmask), .wval(wval), .wr(wr.src)
    );

    csr_exc_regs #(.SAVE_COUNT(SAVE_COUNT)) u_exc_regs (
        .clk(clk), .rst(rst), .wr(wr.dst),
        .exc(exc), .ecode(ecode), .esubcode(esubcode), .pc(pc), .badvaddr(badvaddr),
        .badv_is_pc(badv_is_pc), .badv_is_mem(badv_is_mem), .ertn(ertn),
        .timer_zero(timer_zero), .crmd_plv(crmd_plv), .has_int(has_int),
        .exc_entry(exc_entry), .exc_retaddr(exc_retaddr),
        .crmd_word(crmd_word), .prmd_word(prmd_word), .ecfg_word(ecfg_word),
        .estat_word(estat_word), .era_word(era_word), .badv_word(badv_word),
        .eentry_word(eentry_word), .tid_word(tid_word), .save_word(save_word)
    );

    csr_timer u_timer (
        .clk(clk), .rst(rst), .wr(wr.dst),
        .timer_zero(timer_zero), .tcfg_word(tcfg_word), .tval_word(tval_word)
    );

    csr_read_mux #(.SAVE_COUNT(SAVE_COUNT)) u_read_mux (
        .rnum(rnum),
        .crmd_word(crmd_word), .prmd_word(prmd_word), .ecfg_word(ecfg_word),
        .estat_word(estat_word), .era_word(era_word), .badv_word(badv_word),
        .eentry_word(eentry_word), .tid_word(tid_word), .save_word(save_word),
        .tcfg_word(tcfg_word), .tval_word(tval_word),
        .rval(rval)
    );

endmodule

// ==== hw/csr_wr_if.sv ====
interface csr_wr_if;
    import csr_num_pkg::*;
    import csr_exc_pkg::*;

    logic      we;
    csr_sel_t  sel;
    csr_word_t wmask;
    csr_word_t wval;

    modport src (
        output we,
        output sel,
        output wmask,
        output wval
    );

    modport dst (
        input we,
        input sel,
        input wmask,
        input wval
    );

endinterface

// ==== hw/csr_write_decode.sv ====
module csr_write_decode #(
    parameter int SAVE_COUNT = 4
) (
    input  logic                   we,
    input  csr_num_pkg::csr_num_t  wnum,
    input  csr_exc_pkg::csr_word_t wmask,
    input  csr_exc_pkg::csr_word_t wval,
    csr_wr_if.src                  wr
);
    import csr_num_pkg::*;

    csr_sel_t sel;

    always_comb begin
        sel = SEL_NONE;
        case (wnum)
            CSR_CRMD:   sel = SEL_CRMD;
            CSR_PRMD:   sel = SEL_PRMD;
            CSR_ECFG:   sel = SEL_ECFG;
            CSR_ESTAT:  sel = SEL_ESTAT;
            CSR_ERA:    sel = SEL_ERA;
            CSR_BADV:   sel = SEL_BADV;
            CSR_EENTRY: sel = SEL_EENTRY;
            // save slots beyond SAVE_COUNT do not exist
            CSR_SAVE0: begin
                if (SAVE_COUNT > 0) sel = SEL_SAVE0;
            end
            CSR_SAVE1: begin
                if (SAVE_COUNT > 1) sel = SEL_SAVE1;
            end
            CSR_SAVE2: begin
                if (SAVE_COUNT > 2) sel = SEL_SAVE2;
            end
            CSR_SAVE3: begin
                if (SAVE_COUNT > 3) sel = SEL_SAVE3;
            end
            CSR_TID:    sel = SEL_TID;
            CSR_TCFG:   sel = SEL_TCFG;
            CSR_TVAL:   sel = SEL_TVAL;
            CSR_TICLR:  sel = SEL_TICLR;
            default:    sel = SEL_NONE;
        endcase
    end

    assign wr.we    = we;
    assign wr.sel   = sel;
    assign wr.wmask = wmask;
    assign wr.wval  = wval;

endmodule

// ==== verif/csr_assertions.sv ====
module csr_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic                   exc,
    input csr_exc_pkg::csr_word_t pc,
    input csr_exc_pkg::plv_t      crmd_plv,
    input csr_exc_pkg::csr_word_t exc_retaddr,
    input logic                   has_int
);
    timeunit 1ns;
    timeprecision 1ps;
    import csr_exc_pkg::*;

    int fail_count = 0;

    // exception entry always lands in kernel mode
    plv_zero_after_exc: assert property (
        @(posedge clk) disable iff (rst) exc |=> crmd_plv == plv_t'(0)
    ) else begin
        $error("crmd_plv is not zero the cycle after an exception");
        fail_count++;
    end

    retaddr_after_exc: assert property (
        @(posedge clk) disable iff (rst) exc |=> exc_retaddr == $past(pc)
    ) else begin
        $error("exc_retaddr does not hold the pc of the exception");
        fail_count++;
    end

    quiet_in_reset: assert property (
        @(posedge clk) rst |=> !has_int
    ) else begin
        $error("has_int raised while in reset");
        fail_count++;
    end

endmodule

// ==== verif/csr_tb.sv ====
module csr_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import csr_num_pkg::*;
    import csr_exc_pkg::*;

    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 16;
    localparam int    DRIVE_DELAY  = 2;
    localparam string TRACE_FILE   = "verif/csr_trace.txt";

    logic      clk;
    logic      rst;
    logic      we;
    csr_num_t  wnum;
    csr_word_t wmask;
    csr_word_t wval;
    csr_num_t  rnum;
    csr_word_t rval;
    logic      exc;
    ecode_t    ecode;
    esubcode_t esubcode;
    csr_word_t pc;
    csr_word_t badvaddr;
    logic      badv_is_pc;
    logic      badv_is_mem;
    logic      ertn;
    logic      has_int;
    csr_word_t exc_entry;
    csr_word_t exc_retaddr;
    plv_t      crmd_plv;

    int    error_count;
    int    check_count;
    int    test_count;
    int    failed_tests;
    int    test_errors;
    int    test_checks;
    int    watchdog_cycles;
    string test_name;

    csr_top #(.SAVE_COUNT(4)) dut_i (.*);

    bind csr_top csr_assertions u_assertions (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic advance_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // just before the next rising edge
    task automatic settle_to_sample();
        #(CLK_PERIOD - 2 * DRIVE_DELAY);
    endtask

    task automatic check_word(input string name, input csr_word_t expected,
                              input csr_word_t actual);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            $display("FAIL at %0d ns: %s expected %h got %h", $time, name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            $display("FAIL at %0d ns: %s expected %b got %b", $time, name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_plv(input string name, input plv_t expected, input plv_t actual);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            $display("FAIL at %0d ns: %s expected %0d got %0d", $time, name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic close_test();
        if (test_name != "") begin
            if (test_errors == 0) begin
                $display("test %s: ok, %0d checks", test_name, test_checks);
            end else begin
                $display("test %s: %0d of %0d checks wrong", test_name, test_errors,
                         test_checks);
                failed_tests++;
            end
        end
        test_name = "";
    endtask

    task automatic count_wait_cycles(input int fd, output int total);
        logic [7:0]    op;
        logic [1599:0] rest;
        int            cycles;
        int            n;
        total = 0;
        while ($fscanf(fd, "%s", op) == 1) begin
            if (op == "#") begin
                n = $fgets(rest, fd);
            end else if (op == "N") begin
                n = $fscanf(fd, "%d", cycles);
                total += cycles;
            end
        end
    endtask

    // one trace line per cycle, waits take N cycles
    task automatic run_trace(input int fd);
        logic [7:0]    op;
        logic [255:0]  name;
        logic [1599:0] rest;
        csr_word_t     a;
        csr_word_t     b;
        csr_word_t     c;
        csr_word_t     d;
        csr_word_t     f0;
        csr_word_t     f1;
        int            cycles;
        int            n;
        while ($fscanf(fd, "%s", op) == 1) begin
            case (op)
                "#": n = $fgets(rest, fd);
                "T": begin
                    close_test();
                    n = $fscanf(fd, "%s", name);
                    test_name = string'(name);
                    test_errors = 0;
                    test_checks = 0;
                    test_count++;
                end
                "W": begin
                    n = $fscanf(fd, "%h %h %h", a, b, c);
                    we = 1'b1;
                    wnum = csr_num_t'(a);
                    wmask = b;
                    wval = c;
                    advance_cycle();
                    we = 1'b0;
                end
                "E": begin
                    n = $fscanf(fd, "%h %h %h %h %h %h", a, b, c, d, f0, f1);
                    exc = 1'b1;
                    ecode = ecode_t'(a);
                    esubcode = esubcode_t'(b);
                    pc = c;
                    badvaddr = d;
                    badv_is_pc = f0[0];
                    badv_is_mem = f1[0];
                    advance_cycle();
                    exc = 1'b0;
                    badv_is_pc = 1'b0;
                    badv_is_mem = 1'b0;
                end
                "R": begin
                    ertn = 1'b1;
                    advance_cycle();
                    ertn = 1'b0;
                end
                "N": begin
                    n = $fscanf(fd, "%d", cycles);
                    repeat (cycles) advance_cycle();
                end
                "C": begin
                    n = $fscanf(fd, "%h %h", a, b);
                    rnum = csr_num_t'(a);
                    settle_to_sample();
                    check_word($sformatf("rval[%h]", rnum), b, rval);
                    advance_cycle();
                end
                "I": begin
                    n = $fscanf(fd, "%h", a);
                    settle_to_sample();
                    check_bit("has_int", a[0], has_int);
                    advance_cycle();
                end
                "X": begin
                    n = $fscanf(fd, "%h", a);
                    settle_to_sample();
                    check_word("exc_entry", a, exc_entry);
                    advance_cycle();
                end
                "A": begin
                    n = $fscanf(fd, "%h", a);
                    settle_to_sample();
                    check_word("exc_retaddr", a, exc_retaddr);
                    advance_cycle();
                end
                "P": begin
                    n = $fscanf(fd, "%h", a);
                    settle_to_sample();
                    check_plv("crmd_plv", plv_t'(a), crmd_plv);
                    advance_cycle();
                end
                default: begin
                    $display("unknown operation '%s' in the trace file", op);
                    error_count++;
                    test_errors++;
                end
            endcase
        end
        close_test();
    endtask

    initial begin
        int fd;
        int waits;
        clk = 1'b0;
        rst = 1'b1;
        we = 1'b0;
        wnum = '0;
        wmask = '0;
        wval = '0;
        rnum = '0;
        exc = 1'b0;
        ecode = '0;
        esubcode = '0;
        pc = '0;
        badvaddr = '0;
        badv_is_pc = 1'b0;
        badv_is_mem = 1'b0;
        ertn = 1'b0;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        failed_tests = 0;
        test_errors = 0;
        test_checks = 0;
        test_name = "";
        watchdog_cycles = 0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the trace file %s", TRACE_FILE);
            error_count++;
        end else begin
            count_wait_cycles(fd, waits);
            $fclose(fd);
            watchdog_cycles = waits + 200;
            fd = $fopen(TRACE_FILE, "r");
            repeat (RESET_CYCLES) @(posedge clk);
            #DRIVE_DELAY;
            rst = 1'b0;
            run_trace(fd);
            $fclose(fd);
        end
        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d, assertion errors: %0d",
                 test_count, failed_tests, check_count, error_count,
                 dut_i.u_assertions.fail_count);
        if (error_count == 0 && dut_i.u_assertions.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // limit from the trace waits plus a fixed margin
    initial begin
        wait (watchdog_cycles > 0);
        #(watchdog_cycles * CLK_PERIOD);
        $display("timeout: the trace did not finish within %0d cycles", watchdog_cycles);
        $display("Testbench failed");
        $finish;
    end

endmodule

// ==== verif/csr_trace.txt ====
# ops (hex fields): T name | W num mask val | E code sub pc badv is_pc is_mem | R | N cycles
# C num rval | I has_int | X exc_entry | A exc_retaddr | P crmd_plv
T masked_writes
W 030 ffffffff 12345678
W 030 0000ffff aaaabbbb
C 030 1234bbbb
C 031 00000000
W 033 ff00ff00 deadbeef
C 033 de00be00
W 040 ffff0000 5555ffff
W 040 0000ffff 0000cafe
C 040 5555cafe
W 00c ffffffff 1c000abc
C 00c 1c000a80
X 1c000a80
W 004 ffffffff ffffffff
W 004 00000800 00000000
C 004 000017ff
C 044 00000000
C 123 00000000
T exception_entry
W 000 ffffffff 00000007
C 000 00000007
P 3
E 08 001 1c001000 00000000 1 0
P 0
C 000 00000000
C 001 00000007
C 005 00480000
C 006 1c001000
C 007 1c001000
A 1c001000
W 000 00000007 00000001
E 09 000 1c002040 0000abcd 0 1
C 001 00000001
C 005 00090000
C 006 1c002040
C 007 0000abcd
A 1c002040
T ertn_restore
W 000 ffffffff 00000006
E 0b 000 1c003000 00000000 0 0
C 001 00000006
C 007 0000abcd
P 0
R
C 000 00000006
P 2
I 0
T timer_oneshot
W 041 ffffffff 00000009
C 042 00000008
C 042 00000007
N 5
C 042 00000001
C 042 00000000
C 005 000b0800
C 042 ffffffff
I 0
W 004 00000800 00000800
I 1
W 044 00000001 00000001
I 0
C 005 000b0000
T timer_periodic_swi
W 041 ffffffff 0000000b
C 042 00000008
N 7
C 042 00000000
C 042 00000008
I 1
C 042 00000006
W 041 00000001 00000000
W 044 00000001 00000001
I 0
C 042 00000004
C 041 0000000a
W 004 ffffffff 00000002
W 005 00000003 00000001
I 0
W 005 00000003 00000002
I 1
C 005 000b0002
W 000 00000004 00000000
I 0
